// File: common/axi_lite_consts.svh
`ifndef AXI_LITE_CONSTS_SVH
`define AXI_LITE_CONSTS_SVH

// Bus widths
`define AXI_ADDR_W 16
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)
`define AXI_RESP_W 2
`define AXI_PROT_W 3

// Fixed protection codes, unprivileged secure data for writes
`define AXI_AWPROT_VAL 3'b000
// Privileged access for reads
`define AXI_ARPROT_VAL 3'b001

// SLVERR and DECERR both have bit 1 set
`define AXI_RESP_ERR_BIT 1

`endif

// File: common/axi_lite_pkg.sv
`default_nettype none

`include "axi_lite_consts.svh"

package axi_lite_pkg;

    // Byte address, shared by AW, AR and the local bus
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

    // One data word on W, R and the local bus
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;

    // Byte enables for W
    typedef logic [`AXI_STRB_W-1:0] axi_strb_t;

    // BRESP / RRESP code
    typedef logic [`AXI_RESP_W-1:0] axi_resp_t;

    // AWPROT / ARPROT code
    typedef logic [`AXI_PROT_W-1:0] axi_prot_t;

endpackage

`default_nettype wire

// File: common/axi_lite_if.sv
`default_nettype none

// ---------------------------------------------------------------------------
// Write side: AW, W and B channels
// ---------------------------------------------------------------------------
interface axi_lite_wr_if
    import axi_lite_pkg::*;
();

    // Write address channel
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;

    // Write data channel
    axi_data_t wdata;
    logic      wvalid;
    logic      wready;

    // Write response channel
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;

    modport master (
        output awaddr, awvalid, wdata, wvalid, bready,
        input  awready, wready, bresp, bvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wvalid, bready,
        output awready, wready, bresp, bvalid
    );

endinterface

// ---------------------------------------------------------------------------
// Read side: AR and R channels
// ---------------------------------------------------------------------------
interface axi_lite_rd_if
    import axi_lite_pkg::*;
();

    // Read address channel
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;

    // Read data channel, response rides along with data
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;

    modport master (
        output araddr, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    modport slave (
        input  araddr, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

endinterface

`default_nettype wire

// File: source/axi_lite_write_ctrl.sv
`default_nettype none

`include "axi_lite_consts.svh"

module axi_lite_write_ctrl
    import axi_lite_pkg::*;
(
    input  logic          M_AXI_ACLK,
    input  logic          M_AXI_ARESETN,

    // Local bus write request
    input  logic          wr_req,
    input  axi_addr_t     wr_addr,
    input  axi_data_t     wr_data,
    output logic          wr_busy,
    output logic          wr_err,

    axi_lite_wr_if.master wr_bus
);

    // Captured request payload
    axi_addr_t awaddr_q;
    axi_data_t wdata_q;

    // Channel control flags
    logic awvalid_q;
    logic wvalid_q;
    logic bready_q;

    // bready one cycle late for the falling-edge detect
    logic bready_dly;
    logic bready_fall;

    // ------------------------------------------------------------------------
    // AW and W channels
    // ------------------------------------------------------------------------

    // Payload captured on each request
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (wr_req)
        begin
            awaddr_q <= wr_addr;
            wdata_q  <= wr_data;
        end
    end

    // Both VALIDs rise together and each retires on its own handshake
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
        end
        else
        begin
            if (wr_req)
                awvalid_q <= 1'b1;
            else if (awvalid_q && wr_bus.awready)
                awvalid_q <= 1'b0;

            if (wr_req)
                wvalid_q <= 1'b1;
            else if (wvalid_q && wr_bus.wready)
                wvalid_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // B channel
    // ------------------------------------------------------------------------

    // One-cycle bready pulse per response
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            bready_q   <= 1'b0;
            bready_dly <= 1'b0;
        end
        else
        begin
            bready_q   <= wr_bus.bvalid && !bready_q;
            bready_dly <= bready_q;
        end
    end

    // High in the cycle right after the B transfer
    assign bready_fall = bready_dly && !bready_q;

    // Busy spans request to one cycle after the response is taken
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            wr_busy <= 1'b0;
        else if (wr_req)
            wr_busy <= 1'b1;
        else if (bready_fall)
            wr_busy <= 1'b0;
    end

    // Error only in the B transfer cycle
    assign wr_err = bready_q && wr_bus.bvalid && wr_bus.bresp[`AXI_RESP_ERR_BIT];

    // Drive the bus
    assign wr_bus.awaddr  = awaddr_q;
    assign wr_bus.awvalid = awvalid_q;
    assign wr_bus.wdata   = wdata_q;
    assign wr_bus.wvalid  = wvalid_q;
    assign wr_bus.bready  = bready_q;

    // ------------------------------------------------------------------------
    // Protocol checks
    // ------------------------------------------------------------------------

    // AW holds with stable address until accepted
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        awvalid_q && !wr_bus.awready |=> awvalid_q && $stable(awaddr_q))
    else $error("awvalid dropped or awaddr changed before awready");

    // W holds with stable data until accepted
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        wvalid_q && !wr_bus.wready |=> wvalid_q && $stable(wdata_q))
    else $error("wvalid dropped or wdata changed before wready");

    // Every bready pulse meets a held response
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        bready_q |-> wr_bus.bvalid)
    else $error("bready pulse without bvalid");

    // Single outstanding write so the user side waits for busy low
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        wr_busy |-> !wr_req)
    else $error("wr_req while wr_busy");

endmodule

`default_nettype wire

// File: source/axi_lite_read_ctrl.sv
`default_nettype none

`include "axi_lite_consts.svh"

module axi_lite_read_ctrl
    import axi_lite_pkg::*;
(
    input  logic          M_AXI_ACLK,
    input  logic          M_AXI_ARESETN,

    // Local bus read request and return
    input  logic          rd_req,
    input  axi_addr_t     rd_addr,
    output axi_data_t     rd_data,
    output logic          rd_busy,
    output logic          rd_finish,
    output logic          rd_err,

    axi_lite_rd_if.master rd_bus
);

    // Captured read address
    axi_addr_t araddr_q;

    logic arvalid_q;
    logic rready_q;

    // ------------------------------------------------------------------------
    // AR channel
    // ------------------------------------------------------------------------

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (rd_req)
            araddr_q <= rd_addr;
    end

    // Raised by the request and held until arready
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            arvalid_q <= 1'b0;
        else if (rd_req)
            arvalid_q <= 1'b1;
        else if (arvalid_q && rd_bus.arready)
            arvalid_q <= 1'b0;
    end

    // ------------------------------------------------------------------------
    // R channel
    // ------------------------------------------------------------------------

    // One-cycle rready pulse per returned beat
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            rready_q <= 1'b0;
        else
            rready_q <= rd_bus.rvalid && !rready_q;
    end

    // Finish is the R transfer cycle itself
    assign rd_finish = rd_bus.rvalid && rready_q;

    // Data goes straight through and is valid with rd_finish
    assign rd_data = rd_bus.rdata;

    // Error flag in the finish cycle only
    assign rd_err = rd_finish && rd_bus.rresp[`AXI_RESP_ERR_BIT];

    // Busy from request to the edge after finish
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            rd_busy <= 1'b0;
        else if (rd_req)
            rd_busy <= 1'b1;
        else if (rd_finish)
            rd_busy <= 1'b0;
    end

    assign rd_bus.araddr  = araddr_q;
    assign rd_bus.arvalid = arvalid_q;
    assign rd_bus.rready  = rready_q;

    // ------------------------------------------------------------------------
    // Protocol checks
    // ------------------------------------------------------------------------

    // AR holds with stable address until accepted
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        arvalid_q && !rd_bus.arready |=> arvalid_q && $stable(araddr_q))
    else $error("arvalid dropped or araddr changed before arready");

    // Every rready pulse meets a held beat
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        rready_q |-> rd_bus.rvalid)
    else $error("rready pulse without rvalid");

    // Single outstanding read
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        rd_busy |-> !rd_req)
    else $error("rd_req while rd_busy");

endmodule

`default_nettype wire

// File: source/axi_lite_master.sv
`default_nettype none

`include "axi_lite_consts.svh"

module axi_lite_master
    import axi_lite_pkg::*;
(
    input  logic      M_AXI_ACLK,
    input  logic      M_AXI_ARESETN,

    // ------------------------------------------------------------------------
    // Local bus
    // ------------------------------------------------------------------------

    // Write request, one-cycle pulse
    input  logic      wr_req,
    input  axi_addr_t wr_addr,
    input  axi_data_t wr_data,
    output logic      wr_busy,

    // Read request, one-cycle pulse
    input  logic      rd_req,
    input  axi_addr_t rd_addr,
    output axi_data_t rd_data,
    output logic      rd_busy,
    output logic      rd_finish,

    // Response error strobes
    output logic      wr_err,
    output logic      rd_err,

    // ------------------------------------------------------------------------
    // AXI4-Lite master port
    // ------------------------------------------------------------------------

    // Write address
    output axi_addr_t M_AXI_AWADDR,
    output axi_prot_t M_AXI_AWPROT,
    output logic      M_AXI_AWVALID,
    input  logic      M_AXI_AWREADY,

    // Write data
    output axi_data_t M_AXI_WDATA,
    output axi_strb_t M_AXI_WSTRB,
    output logic      M_AXI_WVALID,
    input  logic      M_AXI_WREADY,

    // Write response
    input  axi_resp_t M_AXI_BRESP,
    input  logic      M_AXI_BVALID,
    output logic      M_AXI_BREADY,

    // Read address
    output axi_addr_t M_AXI_ARADDR,
    output axi_prot_t M_AXI_ARPROT,
    output logic      M_AXI_ARVALID,
    input  logic      M_AXI_ARREADY,

    // Read data and response
    input  axi_data_t M_AXI_RDATA,
    input  axi_resp_t M_AXI_RRESP,
    input  logic      M_AXI_RVALID,
    output logic      M_AXI_RREADY
);

    // Channel bundles between the top and the two controllers
    axi_lite_wr_if wr_bus ();
    axi_lite_rd_if rd_bus ();

    // Slave-driven write signals into the bundle
    assign wr_bus.awready = M_AXI_AWREADY;
    assign wr_bus.wready  = M_AXI_WREADY;
    assign wr_bus.bresp   = M_AXI_BRESP;
    assign wr_bus.bvalid  = M_AXI_BVALID;

    // Slave-driven read signals into the bundle
    assign rd_bus.arready = M_AXI_ARREADY;
    assign rd_bus.rdata   = M_AXI_RDATA;
    assign rd_bus.rresp   = M_AXI_RRESP;
    assign rd_bus.rvalid  = M_AXI_RVALID;

    // Master-driven signals out to the ports
    assign M_AXI_AWADDR  = wr_bus.awaddr;
    assign M_AXI_AWVALID = wr_bus.awvalid;
    assign M_AXI_WDATA   = wr_bus.wdata;
    assign M_AXI_WVALID  = wr_bus.wvalid;
    assign M_AXI_BREADY  = wr_bus.bready;
    assign M_AXI_ARADDR  = rd_bus.araddr;
    assign M_AXI_ARVALID = rd_bus.arvalid;
    assign M_AXI_RREADY  = rd_bus.rready;

    // Fixed protection codes; full-word writes only
    assign M_AXI_AWPROT = `AXI_AWPROT_VAL;
    assign M_AXI_ARPROT = `AXI_ARPROT_VAL;
    assign M_AXI_WSTRB  = {`AXI_STRB_W{1'b1}};

    // Write path, AW + W + B
    axi_lite_write_ctrl i_write_ctrl (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_busy       (wr_busy),
        .wr_err        (wr_err),
        .wr_bus        (wr_bus.master)
    );

    // Read path, AR + R; independent of the write path
    axi_lite_read_ctrl i_read_ctrl (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .rd_busy       (rd_busy),
        .rd_finish     (rd_finish),
        .rd_err        (rd_err),
        .rd_bus        (rd_bus.master)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`default_nettype none

`include "axi_lite_consts.svh"

module tb_clock_gen
    import axi_lite_pkg::*;
(
    output logic M_AXI_ACLK,
    output logic M_AXI_ARESETN
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial
    begin
        M_AXI_ACLK = 1'b0;
        forever #50 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    // Reset low for four rising edges, released on a falling edge
    initial
    begin
        M_AXI_ARESETN = 1'b0;
        repeat (4) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        M_AXI_ARESETN = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/axi_lite_slave_model.sv
`default_nettype none

`include "axi_lite_consts.svh"

module axi_lite_slave_model
    import axi_lite_pkg::*;
(
    input  logic      M_AXI_ACLK,
    input  logic      M_AXI_ARESETN,
    // Addresses that answer with SLVERR
    input  axi_addr_t err_addr [0:3],
    input  axi_addr_t awaddr,
    input  axi_prot_t awprot,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,
    input  axi_addr_t araddr,
    input  axi_prot_t arprot,
    input  logic      arvalid,
    output logic      arready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready
);
    timeunit 1ns;
    timeprecision 1ps;

    integer seed = 32'hf432;

    // Sparse word memory
    axi_data_t mem [axi_addr_t];

    // Captured beats and beat counters, read by the testbench
    int unsigned aw_count;
    int unsigned w_count;
    int unsigned ar_count;
    axi_addr_t   aw_addr_q;
    axi_prot_t   aw_prot_q;
    axi_data_t   w_data_q;
    axi_strb_t   w_strb_q;
    axi_addr_t   ar_addr_q;
    axi_prot_t   ar_prot_q;

    logic       aw_got;
    logic       w_got;
    logic       ar_got;
    // Remaining delay before each READY or response
    logic [2:0] aw_wait;
    logic [2:0] w_wait;
    logic [2:0] b_wait;
    logic [2:0] ar_wait;
    logic [2:0] r_wait;

    // Random 0 to 5 cycles
    function automatic logic [2:0] pick_delay();
        pick_delay = 3'($unsigned($random(seed)) % 6);
    endfunction

    function automatic logic is_err(input axi_addr_t addr);
        is_err = 1'b0;
        for (int i = 0; i < 4; i++)
            if (err_addr[i] == addr)
                is_err = 1'b1;
    endfunction

    initial
    begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = '0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = '0;
    end

    // ------------------------------------------------------------------------
    // Write side, AW and W accepted independently, B once both are in
    // ------------------------------------------------------------------------
    always @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= '0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            aw_count <= 0;
            w_count  <= 0;
            aw_wait  <= pick_delay();
            w_wait   <= pick_delay();
            b_wait   <= pick_delay();
        end
        else
        begin
            // READY is a single-cycle pulse
            awready <= 1'b0;
            wready  <= 1'b0;

            if (awvalid && awready)
            begin
                aw_addr_q <= awaddr;
                aw_prot_q <= awprot;
                aw_got    <= 1'b1;
                aw_count  <= aw_count + 1;
                aw_wait   <= pick_delay();
            end
            else if (awvalid && !aw_got)
            begin
                if (aw_wait == 3'd0)
                    awready <= 1'b1;
                else
                    aw_wait <= aw_wait - 3'd1;
            end

            if (wvalid && wready)
            begin
                w_data_q <= wdata;
                w_strb_q <= wstrb;
                w_got    <= 1'b1;
                w_count  <= w_count + 1;
                w_wait   <= pick_delay();
            end
            else if (wvalid && !w_got)
            begin
                if (w_wait == 3'd0)
                    wready <= 1'b1;
                else
                    w_wait <= w_wait - 3'd1;
            end

            // Response held until bready, error writes are dropped
            if (bvalid && bready)
            begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_wait <= pick_delay();
            end
            else if (aw_got && w_got && !bvalid)
            begin
                if (b_wait == 3'd0)
                begin
                    bvalid <= 1'b1;
                    bresp  <= is_err(aw_addr_q) ? 2'b10 : 2'b00;
                    if (!is_err(aw_addr_q))
                        mem[aw_addr_q] = w_data_q;
                end
                else
                    b_wait <= b_wait - 3'd1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------
    always @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= '0;
            ar_got   <= 1'b0;
            ar_count <= 0;
            ar_wait  <= pick_delay();
            r_wait   <= pick_delay();
        end
        else
        begin
            arready <= 1'b0;

            if (arvalid && arready)
            begin
                ar_addr_q <= araddr;
                ar_prot_q <= arprot;
                ar_got    <= 1'b1;
                ar_count  <= ar_count + 1;
                ar_wait   <= pick_delay();
            end
            else if (arvalid && !ar_got)
            begin
                if (ar_wait == 3'd0)
                    arready <= 1'b1;
                else
                    ar_wait <= ar_wait - 3'd1;
            end

            // Unwritten words read back as an address pattern
            if (rvalid && rready)
            begin
                rvalid <= 1'b0;
                ar_got <= 1'b0;
                r_wait <= pick_delay();
            end
            else if (ar_got && !rvalid)
            begin
                if (r_wait == 3'd0)
                begin
                    rvalid <= 1'b1;
                    rdata  <= mem.exists(ar_addr_q) ? mem[ar_addr_q] : {~ar_addr_q, ar_addr_q};
                    rresp  <= is_err(ar_addr_q) ? 2'b10 : 2'b00;
                end
                else
                    r_wait <= r_wait - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_axi_lite_master.sv
`default_nettype none

`include "axi_lite_consts.svh"

module tb_axi_lite_master
    import axi_lite_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // About 200 transactions of at most 40 cycles, plus margin
    localparam int MAX_CYCLES = 10000;
    localparam int N_RANDOM   = 150;

    logic      M_AXI_ACLK;
    logic      M_AXI_ARESETN;

    // Local bus
    logic      wr_req;
    axi_addr_t wr_addr;
    axi_data_t wr_data;
    logic      wr_busy;
    logic      wr_err;
    logic      rd_req;
    axi_addr_t rd_addr;
    axi_data_t rd_data;
    logic      rd_busy;
    logic      rd_finish;
    logic      rd_err;

    // AXI4-Lite between DUT and slave model
    axi_addr_t awaddr;
    axi_prot_t awprot;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    axi_addr_t araddr;
    axi_prot_t arprot;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;

    axi_addr_t err_list [0:3];
    // Last good value written per address
    axi_data_t shadow [axi_addr_t];
    string     test_name = "reset";
    int        cycles = 0;
    int        wr_err_seen = 0;
    int        rd_finish_seen = 0;
    axi_addr_t exp_rd_addr;
    integer    seed = 32'hf432;

    tb_clock_gen i_clock_gen (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN)
    );

    axi_lite_master i_axi_lite_master (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_busy       (wr_busy),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .rd_busy       (rd_busy),
        .rd_finish     (rd_finish),
        .wr_err        (wr_err),
        .rd_err        (rd_err),
        .M_AXI_AWADDR  (awaddr),
        .M_AXI_AWPROT  (awprot),
        .M_AXI_AWVALID (awvalid),
        .M_AXI_AWREADY (awready),
        .M_AXI_WDATA   (wdata),
        .M_AXI_WSTRB   (wstrb),
        .M_AXI_WVALID  (wvalid),
        .M_AXI_WREADY  (wready),
        .M_AXI_BRESP   (bresp),
        .M_AXI_BVALID  (bvalid),
        .M_AXI_BREADY  (bready),
        .M_AXI_ARADDR  (araddr),
        .M_AXI_ARPROT  (arprot),
        .M_AXI_ARVALID (arvalid),
        .M_AXI_ARREADY (arready),
        .M_AXI_RDATA   (rdata),
        .M_AXI_RRESP   (rresp),
        .M_AXI_RVALID  (rvalid),
        .M_AXI_RREADY  (rready)
    );

    axi_lite_slave_model i_slave (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .err_addr      (err_list),
        .awaddr        (awaddr),
        .awprot        (awprot),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arprot        (arprot),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready)
    );

    // ------------------------------------------------------------------------
    // Reference model and compare tasks
    // ------------------------------------------------------------------------
    function automatic logic addr_is_err(input axi_addr_t addr);
        addr_is_err = 1'b0;
        for (int i = 0; i < 4; i++)
            if (err_list[i] == addr)
                addr_is_err = 1'b1;
    endfunction

    // Last value written, else a pattern built from the whole address
    function automatic axi_data_t ref_read(input axi_addr_t addr, output logic err);
        err = addr_is_err(addr);
        if (shadow.exists(addr))
            return shadow[addr];
        return {~addr, addr};
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_addr(input string what, input axi_addr_t exp, input axi_addr_t act);
        if (exp !== act)
        begin
            $display("ERROR: %s: %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_data(input string what, input axi_data_t exp, input axi_data_t act);
        if (exp !== act)
        begin
            $display("ERROR: %s: %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_prot(input string what, input axi_prot_t exp, input axi_prot_t act);
        if (exp !== act)
        begin
            $display("ERROR: %s: %s expected %b actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_strb(input string what, input axi_strb_t exp, input axi_strb_t act);
        if (exp !== act)
        begin
            $display("ERROR: %s: %s expected %b actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("ERROR: %s: %s expected %b actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act)
        begin
            $display("ERROR: %s: %s expected %0d actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // Local bus drivers, inputs change on falling edges
    // ------------------------------------------------------------------------
    task automatic do_write(input axi_addr_t addr, input axi_data_t data);
        int   aw_before;
        int   w_before;
        int   err_before;
        logic exp_err;
        aw_before  = i_slave.aw_count;
        w_before   = i_slave.w_count;
        err_before = wr_err_seen;
        exp_err    = addr_is_err(addr);
        wr_addr = addr;
        wr_data = data;
        wr_req  = 1'b1;
        @(negedge M_AXI_ACLK);
        wr_req = 1'b0;
        check_flag("wr_busy after request", 1'b1, wr_busy);
        while (wr_busy)
            @(negedge M_AXI_ACLK);
        // Exactly one beat per channel
        check_count("AW beats", aw_before + 1, i_slave.aw_count);
        check_count("W beats", w_before + 1, i_slave.w_count);
        check_addr("awaddr", addr, i_slave.aw_addr_q);
        check_data("wdata", data, i_slave.w_data_q);
        check_strb("wstrb", 4'b1111, i_slave.w_strb_q);
        check_prot("awprot", 3'b000, i_slave.aw_prot_q);
        check_count("wr_err pulses", exp_err ? 1 : 0, wr_err_seen - err_before);
        if (!exp_err)
            shadow[addr] = data;
    endtask

    task automatic do_read(input axi_addr_t addr);
        int ar_before;
        int fin_before;
        ar_before   = i_slave.ar_count;
        fin_before  = rd_finish_seen;
        exp_rd_addr = addr;
        rd_addr = addr;
        rd_req  = 1'b1;
        @(negedge M_AXI_ACLK);
        rd_req = 1'b0;
        check_flag("rd_busy after request", 1'b1, rd_busy);
        while (rd_busy)
            @(negedge M_AXI_ACLK);
        check_count("AR beats", ar_before + 1, i_slave.ar_count);
        check_count("rd_finish strobes", fin_before + 1, rd_finish_seen);
        check_addr("araddr", addr, i_slave.ar_addr_q);
        check_prot("arprot", 3'b001, i_slave.ar_prot_q);
    endtask

    function automatic axi_addr_t pick_addr();
        int r;
        r = int'($unsigned($random(seed)) % 20);
        // One pick in five hits an error address
        if (r >= 16)
            return err_list[r - 16];
        return axi_addr_t'(r * 4);
    endfunction

    // Compares read returns and error strobes on every falling edge
    always @(negedge M_AXI_ACLK)
    begin
        axi_data_t exp_data;
        logic      exp_err;
        if (M_AXI_ARESETN)
        begin
            if (rd_finish)
            begin
                exp_data = ref_read(exp_rd_addr, exp_err);
                check_flag("rd_err at finish", exp_err, rd_err);
                if (!exp_err)
                    check_data("rd_data", exp_data, rd_data);
                rd_finish_seen++;
            end
            else
                check_flag("rd_err outside finish", 1'b0, rd_err);
            if (wr_err)
            begin
                check_flag("wr_busy during wr_err", 1'b1, wr_busy);
                wr_err_seen++;
            end
        end
    end

    always @(posedge M_AXI_ACLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial
    begin
        int        op;
        axi_addr_t a_wr;
        axi_addr_t a_rd;
        axi_data_t d;
        wr_req  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_req  = 1'b0;
        rd_addr = '0;
        err_list[0] = 16'h0100;
        err_list[1] = 16'h0204;
        err_list[2] = 16'h0308;
        err_list[3] = 16'h040c;

        @(posedge M_AXI_ARESETN);
        @(negedge M_AXI_ACLK);
        check_flag("idle outputs", 1'b0, awvalid | wvalid | bready | arvalid | rready);
        check_flag("idle status", 1'b0, wr_busy | rd_busy | rd_finish | wr_err | rd_err);

        test_name = "single_write";
        do_write(16'h0010, 32'hdead_beef);
        test_name = "single_read";
        do_read(16'h0010);
        test_name = "write_error";
        do_write(err_list[1], 32'h1234_5678);
        test_name = "read_error";
        do_read(err_list[2]);

        // Each write read back straight away under random delays
        test_name = "back_pressure";
        for (int k = 0; k < 20; k++)
        begin
            a_wr = axi_addr_t'((k * 4) % 64);
            d    = $random(seed);
            do_write(a_wr, d);
            do_read(a_wr);
        end

        // Concurrent pairs never touch the same address
        test_name = "random_mix";
        for (int n = 0; n < N_RANDOM; n++)
        begin
            op   = int'($unsigned($random(seed)) % 3);
            a_wr = pick_addr();
            a_rd = pick_addr();
            if (a_rd == a_wr)
                a_rd = a_rd ^ 16'h0004;
            d = $random(seed);
            case (op)
                0: do_write(a_wr, d);
                1: do_read(a_rd);
                default:
                begin
                    fork
                        do_write(a_wr, d);
                        do_read(a_rd);
                    join
                end
            endcase
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/axi_lite_pkg.sv
common/axi_lite_if.sv
source/axi_lite_write_ctrl.sv
source/axi_lite_read_ctrl.sv
source/axi_lite_master.sv
verif/tb_clock_gen.sv
verif/axi_lite_slave_model.sv
verif/tb_axi_lite_master.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_axi_lite_master
FILELIST   := all.f
COMMON     := --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert -j 0 $(COMMON)
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the log holds the pass message on a line of its own
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
